// ==== design/controlConsts.svh ====
`ifndef CONTROL_CONSTS_SVH
`define CONTROL_CONSTS_SVH

// Opcode field inside the instruction word
`define OPCODE_MSB 31
`define OPCODE_LSB 27

// Processor data path width
`define WORD_WIDTH 32

// Execute step counter
`define STEP_WIDTH 3

// Longest execute sequence (load)
`define MAX_EXEC_STEPS 5

`endif

// ==== design/isaPkg.sv ====
`include "controlConsts.svh"

package isaPkg;

	typedef logic [`WORD_WIDTH-1:0] word_t;
	typedef logic [`OPCODE_MSB-`OPCODE_LSB:0] opcodeField_t;

	// Supported opcodes, encodings as in the ISA
	typedef enum opcodeField_t {
		opLoad    = 5'd0,
		opLoadImm = 5'd1,
		opStore   = 5'd2,
		opAdd     = 5'd3,
		opSub     = 5'd4,
		opShr     = 5'd5,
		opShra    = 5'd6,
		opShl     = 5'd7,
		opRor     = 5'd8,
		opRol     = 5'd9,
		opAnd     = 5'd10,
		opOr      = 5'd11,
		opAddImm  = 5'd12,
		opAndImm  = 5'd13,
		opOrImm   = 5'd14,
		opNeg     = 5'd17,
		opNot     = 5'd18,
		opBranch  = 5'd19,
		opJumpReg = 5'd20,
		opNop     = 5'd26,
		opHalt    = 5'd27
	} opcode_t;

	// Groups of opcodes that share one step sequence
	typedef enum logic [3:0] {
		classLoad, classLoadImm, classStore, classAluReg, classAluImm,
		classBranch, classJumpReg, classNop, classHalt
	} instrClass_t;

endpackage

// ==== design/controlPkg.sv ====
`include "controlConsts.svh"

package controlPkg;

	// Execute step counter
	typedef logic [`STEP_WIDTH-1:0] step_t;

	// Who drives the single bus in a step
	// srcRegister is Rout, srcBaseRegister is BAout
	typedef enum logic [2:0] {
		srcNone, srcPc, srcMdr, srcZLow, srcRegister, srcBaseRegister, srcCSign
	} busSource_t;

	typedef enum logic [3:0] {
		aluNone, aluAdd, aluSub, aluAnd, aluOr,
		aluShr, aluShra, aluShl, aluRor, aluRol,
		aluNegate, aluNot, aluIncPc, aluBranch
	} aluOp_t;

	// Register field of the IR that addresses the register file
	typedef enum logic [1:0] {
		fieldNone, fieldA, fieldB, fieldC
	} regField_t;

	typedef enum logic [2:0] {
		phaseReset,
		phaseFetch0,
		phaseFetch1,
		phaseFetch2,
		phaseExecute,
		phaseHalted
	} phase_t;

endpackage

// ==== design/controlStepIf.sv ====
`timescale 1ns/100ps

interface controlStepIf (
	input logic clock
);
	import isaPkg::*;
	import controlPkg::*;

	// From the sequencer
	phase_t phase;
	step_t step;

	// From the decoder
	instrClass_t instrClass;
	aluOp_t operation;
	step_t execLength;

	modport sequencer (output phase, step, input execLength, instrClass);

	modport decoder (output instrClass, operation, execLength);

	// Shared by both step tables
	modport tables (input clock, phase, step, instrClass, operation, execLength);

endinterface

// ==== design/opcodeDecoder.sv ====
`timescale 1ns/100ps
`include "controlConsts.svh"

module opcodeDecoder (
	input isaPkg::word_t ir,
	controlStepIf.decoder step
);
	import isaPkg::*;
	import controlPkg::*;

	opcodeField_t opcodeBits;
	instrClass_t instrClass;
	aluOp_t operation;
	step_t execLength;

	assign opcodeBits = ir[`OPCODE_MSB:`OPCODE_LSB];

	// Class and ALU operation per opcode
	always_comb begin
		instrClass = classNop;
		operation = aluNone;
		case (opcodeBits)
			opLoad: begin
				instrClass = classLoad;
				operation = aluAdd;
			end
			opLoadImm: begin
				instrClass = classLoadImm;
				operation = aluAdd;
			end
			opStore: begin
				instrClass = classStore;
				operation = aluAdd;
			end
			opAdd: begin
				instrClass = classAluReg;
				operation = aluAdd;
			end
			opSub: begin
				instrClass = classAluReg;
				operation = aluSub;
			end
			opAnd: begin
				instrClass = classAluReg;
				operation = aluAnd;
			end
			opOr: begin
				instrClass = classAluReg;
				operation = aluOr;
			end
			// Shifts and rotates use the same three steps as add
			opShr: begin
				instrClass = classAluReg;
				operation = aluShr;
			end
			opShra: begin
				instrClass = classAluReg;
				operation = aluShra;
			end
			opShl: begin
				instrClass = classAluReg;
				operation = aluShl;
			end
			opRor: begin
				instrClass = classAluReg;
				operation = aluRor;
			end
			opRol: begin
				instrClass = classAluReg;
				operation = aluRol;
			end
			opNeg: begin
				instrClass = classAluReg;
				operation = aluNegate;
			end
			opNot: begin
				instrClass = classAluReg;
				operation = aluNot;
			end
			opAddImm: begin
				instrClass = classAluImm;
				operation = aluAdd;
			end
			opAndImm: begin
				instrClass = classAluImm;
				operation = aluAnd;
			end
			opOrImm: begin
				instrClass = classAluImm;
				operation = aluOr;
			end
			opBranch: instrClass = classBranch;
			opJumpReg: instrClass = classJumpReg;
			opHalt: instrClass = classHalt;
			// Anything else idles for one step
			default: instrClass = classNop;
		endcase
	end

	// Number of execute steps per class
	always_comb begin
		case (instrClass)
			classLoad: execLength = step_t'(`MAX_EXEC_STEPS);
			classStore, classBranch: execLength = step_t'(4);
			classLoadImm, classAluReg, classAluImm: execLength = step_t'(3);
			default: execLength = step_t'(1);
		endcase
	end

	assign step.instrClass = instrClass;
	assign step.operation = operation;
	assign step.execLength = execLength;

endmodule

// ==== design/stepSequencer.sv ====
`timescale 1ns/100ps

module stepSequencer (
	input logic clock,
	input logic reset,
	controlStepIf.sequencer step,
	output logic clear
);
	import isaPkg::*;
	import controlPkg::*;

	phase_t phase;
	step_t count;
	logic lastStep;

	assign lastStep = (count == step.execLength - step_t'(1));

	// ------------------------------
	// Phase and step state machine
	// ------------------------------
	always_ff @(posedge clock, posedge reset) begin
		if (reset) begin
			phase <= phaseReset;
			count <= '0;
		end else begin
			case (phase)
				phaseReset: phase <= phaseFetch0;
				phaseFetch0: phase <= phaseFetch1;
				phaseFetch1: phase <= phaseFetch2;
				phaseFetch2: begin
					phase <= phaseExecute;
					count <= '0;
				end
				phaseExecute: begin
					if (lastStep) begin
						count <= '0;
						if (step.instrClass == classHalt) begin
							phase <= phaseHalted;
						end else begin
							phase <= phaseFetch0;
						end
					end else begin
						count <= count + step_t'(1);
					end
				end
				// Only reset gets out of here
				phaseHalted: phase <= phaseHalted;
				default: phase <= phaseReset;
			endcase
		end
	end

	assign step.phase = phase;
	assign step.step = count;

	// Clears the data path registers
	assign clear = (phase == phaseReset);

	// ------------------------------
	// Assertions
	// ------------------------------

	// Decoded length bounds the counter in every execute step
	stepBelowLength: assert property (
		@(posedge clock) disable iff (reset)
		phase == phaseExecute |-> count < step.execLength
	) else $error("execute step %0d reached length %0d", count, step.execLength);

	haltedIsSticky: assert property (
		@(posedge clock) disable iff (reset)
		phase == phaseHalted |=> phase == phaseHalted
	) else $error("left halted phase without reset");

endmodule

// ==== design/busTransferTable.sv ====
`timescale 1ns/100ps

module busTransferTable (
	controlStepIf.tables step,
	input logic conditionFlag,
	output controlPkg::busSource_t busSource,
	output controlPkg::regField_t registerSelect,
	output logic registerIn,
	output logic mdrIn,
	output logic marIn,
	output logic yIn,
	output logic irIn,
	output logic pcIn,
	output logic conIn,
	output logic zLowIn
);
	import isaPkg::*;
	import controlPkg::*;

	always_comb begin
		busSource = srcNone;
		registerSelect = fieldNone;
		registerIn = 1'b0;
		mdrIn = 1'b0;
		marIn = 1'b0;
		yIn = 1'b0;
		irIn = 1'b0;
		pcIn = 1'b0;
		conIn = 1'b0;
		zLowIn = 1'b0;
		case (step.phase)
			// ------------------------------
			// Fetch
			// ------------------------------
			phaseFetch0: begin
				busSource = srcPc;
				marIn = 1'b1;
				zLowIn = 1'b1;
			end
			phaseFetch1: begin
				busSource = srcZLow;
				pcIn = 1'b1;
				mdrIn = 1'b1;
			end
			phaseFetch2: begin
				busSource = srcMdr;
				irIn = 1'b1;
			end
			// ------------------------------
			// Execute
			// ------------------------------
			phaseExecute: begin
				case (step.instrClass)
					// Address is base register plus sign extended C
					classLoad, classLoadImm, classStore: begin
						case (step.step)
							step_t'(0): begin
								busSource = srcBaseRegister;
								registerSelect = fieldB;
								yIn = 1'b1;
							end
							step_t'(1): begin
								busSource = srcCSign;
								zLowIn = 1'b1;
							end
							step_t'(2): begin
								busSource = srcZLow;
								if (step.instrClass == classLoadImm) begin
									registerSelect = fieldA;
									registerIn = 1'b1;
								end else begin
									marIn = 1'b1;
								end
							end
							step_t'(3): begin
								if (step.instrClass == classStore) begin
									busSource = srcBaseRegister;
									registerSelect = fieldA;
								end else begin
									mdrIn = 1'b1;
								end
							end
							step_t'(4): begin
								busSource = srcMdr;
								registerSelect = fieldA;
								registerIn = 1'b1;
							end
							default: ;
						endcase
					end
					classAluReg, classAluImm: begin
						case (step.step)
							step_t'(0): begin
								busSource = srcRegister;
								registerSelect = fieldB;
								yIn = 1'b1;
							end
							step_t'(1): begin
								// Second operand is Rc or the constant
								if (step.instrClass == classAluImm) begin
									busSource = srcCSign;
								end else begin
									busSource = srcRegister;
									registerSelect = fieldC;
								end
								zLowIn = 1'b1;
							end
							step_t'(2): begin
								busSource = srcZLow;
								registerSelect = fieldA;
								registerIn = 1'b1;
							end
							default: ;
						endcase
					end
					classBranch: begin
						case (step.step)
							step_t'(0): begin
								busSource = srcRegister;
								registerSelect = fieldA;
								conIn = 1'b1;
							end
							step_t'(1): begin
								busSource = srcPc;
								yIn = 1'b1;
							end
							step_t'(2): begin
								busSource = srcCSign;
								zLowIn = 1'b1;
							end
							step_t'(3): begin
								// Target only taken when CON FF is set
								busSource = srcZLow;
								pcIn = conditionFlag;
							end
							default: ;
						endcase
					end
					classJumpReg: begin
						busSource = srcRegister;
						registerSelect = fieldA;
						pcIn = 1'b1;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	registerWriteHasField: assert property (
		@(posedge step.clock)
		$rose(registerIn) |-> registerSelect != fieldNone
	) else $error("register write with no register field selected");

endmodule

// ==== design/aluMemoryTable.sv ====
`timescale 1ns/100ps

module aluMemoryTable (
	controlStepIf.tables step,
	output controlPkg::aluOp_t aluOperation,
	output logic memRead,
	output logic memWrite
);
	import isaPkg::*;
	import controlPkg::*;

	always_comb begin
		aluOperation = aluNone;
		memRead = 1'b0;
		memWrite = 1'b0;
		case (step.phase)
			// PC plus one goes to Z while the PC is on the bus
			phaseFetch0: aluOperation = aluIncPc;
			phaseFetch1: memRead = 1'b1;
			phaseExecute: begin
				case (step.instrClass)
					classLoad, classStore: begin
						if (step.step == step_t'(1)) begin
							aluOperation = step.operation;
						end
						if (step.step == step_t'(3)) begin
							memRead = (step.instrClass == classLoad);
							memWrite = (step.instrClass == classStore);
						end
					end
					classLoadImm, classAluReg, classAluImm: begin
						if (step.step == step_t'(1)) begin
							aluOperation = step.operation;
						end
					end
					classBranch: begin
						// PC plus offset, condition applied later
						if (step.step == step_t'(2)) begin
							aluOperation = aluBranch;
						end
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	// ------------------------------
	// Memory port sanity
	// ------------------------------
	memoryExclusive: assert property (
		@(posedge step.clock)
		!(memRead && memWrite)
	) else $error("memory read and write in the same cycle");

endmodule

// ==== design/controlUnit.sv ====
`timescale 1ns/100ps

module controlUnit (
	input logic clock,
	input logic reset,
	input logic conditionFlag,
	input isaPkg::word_t ir,
	output logic clear,
	output controlPkg::busSource_t busSource,
	output controlPkg::regField_t registerSelect,
	output logic registerIn,
	output logic mdrIn,
	output logic marIn,
	output logic yIn,
	output logic irIn,
	output logic pcIn,
	output logic conIn,
	output logic zLowIn,
	output controlPkg::aluOp_t aluOperation,
	output logic memRead,
	output logic memWrite
);

	controlStepIf stepBus (
		.clock(clock)
	);

	opcodeDecoder decoder0 (
		.ir(ir),
		.step(stepBus)
	);

	stepSequencer sequencer0 (
		.clock(clock),
		.reset(reset),
		.step(stepBus),
		.clear(clear)
	);

	// Bus side of the control word
	busTransferTable busTable0 (
		.step(stepBus),
		.conditionFlag(conditionFlag),
		.busSource(busSource),
		.registerSelect(registerSelect),
		.registerIn(registerIn),
		.mdrIn(mdrIn),
		.marIn(marIn),
		.yIn(yIn),
		.irIn(irIn),
		.pcIn(pcIn),
		.conIn(conIn),
		.zLowIn(zLowIn)
	);

	aluMemoryTable aluTable0 (
		.step(stepBus),
		.aluOperation(aluOperation),
		.memRead(memRead),
		.memWrite(memWrite)
	);

endmodule

// ==== testbench/controlUnitChecks.sv ====
`timescale 1ns/100ps
`include "controlConsts.svh"

module controlUnitChecks (
	input logic clock,
	input logic reset,
	input logic conditionFlag,
	input isaPkg::word_t ir,
	input logic clear,
	input controlPkg::busSource_t busSource,
	input controlPkg::regField_t registerSelect,
	input logic registerIn,
	input logic mdrIn,
	input logic marIn,
	input logic yIn,
	input logic irIn,
	input logic pcIn,
	input logic conIn,
	input logic zLowIn,
	input controlPkg::aluOp_t aluOperation,
	input logic memRead,
	input logic memWrite,
	output logic failed,
	output logic halted
);
	import isaPkg::*;
	import controlPkg::*;

	// Strobe bits, same order as the strobes vector below
	localparam logic [9:0] regInBit = 10'b10_0000_0000;
	localparam logic [9:0] mdrInBit = 10'b01_0000_0000;
	localparam logic [9:0] marInBit = 10'b00_1000_0000;
	localparam logic [9:0] irInBit = 10'b00_0010_0000;
	localparam logic [9:0] pcInBit = 10'b00_0001_0000;
	localparam logic [9:0] zLowInBit = 10'b00_0000_0100;
	localparam logic [9:0] memReadBit = 10'b00_0000_0010;

	phase_t modelPhase;
	int modelStep;
	logic [4:0] opcode;
	instrClass_t modelClass;
	logic [9:0] strobes;
	logic [18:0] controls;
	logic inExecute;

	function automatic instrClass_t classOf(input logic [4:0] code);
		case (code)
			5'd0: return classLoad;
			5'd1: return classLoadImm;
			5'd2: return classStore;
			5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9: return classAluReg;
			5'd10, 5'd11, 5'd17, 5'd18: return classAluReg;
			5'd12, 5'd13, 5'd14: return classAluImm;
			5'd19: return classBranch;
			5'd20: return classJumpReg;
			5'd27: return classHalt;
			default: return classNop;
		endcase
	endfunction

	// Execute steps per class
	function automatic int lengthOf(input instrClass_t cls);
		case (cls)
			classLoad: return 5;
			classStore, classBranch: return 4;
			classLoadImm, classAluReg, classAluImm: return 3;
			default: return 1;
		endcase
	endfunction

	function automatic aluOp_t expectedAluOp(input logic [4:0] code);
		case (code)
			5'd0, 5'd1, 5'd2, 5'd3, 5'd12: return aluAdd;
			5'd4: return aluSub;
			5'd5: return aluShr;
			5'd6: return aluShra;
			5'd7: return aluShl;
			5'd8: return aluRor;
			5'd9: return aluRol;
			5'd10, 5'd13: return aluAnd;
			5'd11, 5'd14: return aluOr;
			5'd17: return aluNegate;
			5'd18: return aluNot;
			default: return aluNone;
		endcase
	endfunction

	function automatic logic [18:0] controlWord(input busSource_t src, input regField_t field,
			input aluOp_t op, input logic [9:0] bits);
		return {src, field, op, bits};
	endfunction

	assign opcode = ir[`OPCODE_MSB:`OPCODE_LSB];
	assign modelClass = classOf(opcode);
	assign strobes = {registerIn, mdrIn, marIn, yIn, irIn, pcIn, conIn, zLowIn, memRead, memWrite};
	assign controls = {busSource, registerSelect, aluOperation, strobes};
	assign inExecute = (modelPhase == phaseExecute);
	assign halted = (modelPhase == phaseHalted);

	// ------------------------------
	// Reference sequence
	// ------------------------------
	always @(posedge clock, posedge reset) begin
		if (reset) begin
			modelPhase <= phaseReset;
			modelStep <= 0;
		end else begin
			case (modelPhase)
				phaseReset: modelPhase <= phaseFetch0;
				phaseFetch0: modelPhase <= phaseFetch1;
				phaseFetch1: modelPhase <= phaseFetch2;
				phaseFetch2: begin
					modelPhase <= phaseExecute;
					modelStep <= 0;
				end
				phaseExecute: begin
					if (modelStep == lengthOf(modelClass) - 1) begin
						modelStep <= 0;
						modelPhase <= (modelClass == classHalt) ? phaseHalted : phaseFetch0;
					end else begin
						modelStep <= modelStep + 1;
					end
				end
				default: modelPhase <= modelPhase;
			endcase
		end
	end

	initial failed = 1'b0;

	task automatic reportFailure(input string message);
		$display("[FAIL] time %0d ns: %s", $time, message);
		failed = 1'b1;
	endtask

	// ------------------------------
	// Reset, fetch and halt
	// ------------------------------
	resetIdle: assert property (@(posedge clock)
		modelPhase == phaseReset |-> controls == controlWord(srcNone, fieldNone, aluNone, '0))
		else reportFailure("control outputs active in reset phase");

	clearOnlyInReset: assert property (@(posedge clock)
		clear == (modelPhase == phaseReset))
		else reportFailure("clear does not match the reset phase");

	fetch0Pattern: assert property (@(posedge clock) disable iff (reset)
		modelPhase == phaseFetch0 |->
		controls == controlWord(srcPc, fieldNone, aluIncPc, marInBit | zLowInBit))
		else reportFailure("wrong fetch0 control word");

	fetch1Pattern: assert property (@(posedge clock) disable iff (reset)
		modelPhase == phaseFetch1 |->
		controls == controlWord(srcZLow, fieldNone, aluNone, pcInBit | mdrInBit | memReadBit))
		else reportFailure("wrong fetch1 control word");

	fetch2Pattern: assert property (@(posedge clock) disable iff (reset)
		modelPhase == phaseFetch2 |-> controls == controlWord(srcMdr, fieldNone, aluNone, irInBit))
		else reportFailure("wrong fetch2 control word");

	haltedIdle: assert property (@(posedge clock) disable iff (reset)
		halted |-> controls == controlWord(srcNone, fieldNone, aluNone, '0))
		else reportFailure("outputs active after halt");

	// DUT back in fetch while the instruction should still run
	noFetchInExecute: assert property (@(posedge clock) disable iff (reset)
		inExecute |-> aluOperation != aluIncPc && !irIn)
		else reportFailure("fetch started before the execute steps ended");

	// ------------------------------
	// Execute steps
	// ------------------------------
	idleStep: assert property (@(posedge clock) disable iff (reset)
		inExecute && (modelClass == classNop || modelClass == classHalt) |->
		controls == controlWord(srcNone, fieldNone, aluNone, '0))
		else reportFailure("idle execute step drives outputs");

	operationInStep1: assert property (@(posedge clock) disable iff (reset)
		inExecute && modelStep == 1 && modelClass inside {classLoad, classLoadImm, classStore,
		classAluReg, classAluImm} |-> aluOperation == expectedAluOp(opcode))
		else reportFailure("ALU operation does not match the opcode");

	secondOperand: assert property (@(posedge clock) disable iff (reset)
		inExecute && modelStep == 1 && (modelClass == classAluReg || modelClass == classAluImm)
		|-> zLowIn && (modelClass == classAluImm ?
		(busSource == srcCSign && registerSelect == fieldNone) :
		(busSource == srcRegister && registerSelect == fieldC)))
		else reportFailure("wrong second ALU operand source");

	aluWriteBack: assert property (@(posedge clock) disable iff (reset)
		inExecute && modelStep == 2 && (modelClass == classAluReg || modelClass == classAluImm)
		|-> controls == controlWord(srcZLow, fieldA, aluNone, regInBit))
		else reportFailure("wrong ALU result write back");

	loadRead: assert property (@(posedge clock) disable iff (reset)
		inExecute && modelClass == classLoad && modelStep == 3 |->
		controls == controlWord(srcNone, fieldNone, aluNone, mdrInBit | memReadBit))
		else reportFailure("load does not read memory in step 3");

	loadWriteBack: assert property (@(posedge clock) disable iff (reset)
		inExecute && modelClass == classLoad && modelStep == 4 |->
		controls == controlWord(srcMdr, fieldA, aluNone, regInBit))
		else reportFailure("load does not write the register from MDR");

	storeWrite: assert property (@(posedge clock) disable iff (reset)
		inExecute && modelClass == classStore && modelStep == 3 |-> memWrite)
		else reportFailure("store missing memory write in step 3");

	writeOnlyInStore: assert property (@(posedge clock) disable iff (reset)
		memWrite |-> inExecute && modelClass == classStore && modelStep == 3)
		else reportFailure("memory write outside store step 3");

	memoryExclusive: assert property (@(posedge clock) disable iff (reset)
		!(memRead && memWrite))
		else reportFailure("memory read and write together");

	branchTarget: assert property (@(posedge clock) disable iff (reset)
		inExecute && modelClass == classBranch && modelStep == 3 |->
		busSource == srcZLow && pcIn == conditionFlag)
		else reportFailure("branch PC load does not follow the condition");

	jumpRegister: assert property (@(posedge clock) disable iff (reset)
		inExecute && modelClass == classJumpReg |->
		controls == controlWord(srcRegister, fieldA, aluNone, pcInBit))
		else reportFailure("wrong jump register step");

endmodule

// ==== testbench/controlUnitTb.sv ====
`timescale 1ns/100ps

module controlUnitTb;
	import isaPkg::*;
	import controlPkg::*;

	localparam int programLength = 200;
	localparam int cycleLimit = programLength * 8 + 100;
	// Cycles watched after halt
	localparam int haltWatchCycles = 20;
	localparam logic [4:0] haltOpcode = 5'd27;
	localparam logic [4:0] nopOpcode = 5'd26;

	logic clock;
	logic reset;
	logic conditionFlag;
	word_t ir;
	logic clear;
	busSource_t busSource;
	regField_t registerSelect;
	logic registerIn;
	logic mdrIn;
	logic marIn;
	logic yIn;
	logic irIn;
	logic pcIn;
	logic conIn;
	logic zLowIn;
	aluOp_t aluOperation;
	logic memRead;
	logic memWrite;
	logic failed;
	logic halted;

	word_t programWords [0:programLength];
	int fetchIndex;
	int cycleCount;
	integer seed;
	integer flagDraw;

	controlUnit dut0 (.*);

	controlUnitChecks checks0 (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Random opcodes with halt only as the last word
	task automatic buildProgram();
		integer draw;
		logic [4:0] opcode;
		int index;
		for (index = 0; index < programLength; index++) begin
			do begin
				draw = $random(seed);
				opcode = draw[4:0];
			end while (opcode == haltOpcode);
			draw = $random(seed);
			programWords[index] = {opcode, draw[26:0]};
		end
		programWords[programLength] = {haltOpcode, 27'd0};
	endtask

	task automatic endRun(input logic passed);
		if (passed) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("CHECKS FAILED");
			$fatal(1, "simulation stopped on error");
		end
	endtask

	// ------------------------------
	// Instruction memory and flag
	// ------------------------------
	always @(posedge clock) begin
		flagDraw = $random(seed);
		conditionFlag <= flagDraw[0];
		if (irIn && fetchIndex <= programLength) begin
			ir <= programWords[fetchIndex];
			fetchIndex <= fetchIndex + 1;
		end
	end

	initial begin
		seed = 83;
		reset <= 1'b1;
		conditionFlag = 1'b0;
		ir = {nopOpcode, 27'd0};
		fetchIndex = 0;
		buildProgram();
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		wait (halted === 1'b1);
		repeat (haltWatchCycles) @(posedge clock);
		endRun(!failed);
	end

	initial begin
		wait (failed === 1'b1);
		endRun(1'b0);
	end

	// Watchdog
	initial begin
		cycleCount = 0;
		while (cycleCount < cycleLimit) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("Timeout after %0d cycles, the program never reached halt", cycleCount);
		endRun(1'b0);
	end

endmodule

// ==== sources.f ====
+incdir+design
design/isaPkg.sv
design/controlPkg.sv
design/controlStepIf.sv
design/opcodeDecoder.sv
design/stepSequencer.sv
design/busTransferTable.sv
design/aluMemoryTable.sv
design/controlUnit.sv
testbench/controlUnitChecks.sv
testbench/controlUnitTb.sv

// ==== Bender.yml ====
package:
  name: control_unit

export_include_dirs:
  - design

sources:
  - files:
      - design/isaPkg.sv
      - design/controlPkg.sv
      - design/controlStepIf.sv
      - design/opcodeDecoder.sv
      - design/stepSequencer.sv
      - design/busTransferTable.sv
      - design/aluMemoryTable.sv
      - design/controlUnit.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/controlUnitChecks.sv
      - testbench/controlUnitTb.sv
